// File: cnn_stream.f
source/cnn_types_pkg.sv
source/cnn_weights_pkg.sv
source/pixel_counter.sv
source/conv_ctrl.sv
source/line_buffer.sv
source/mac_array.sv
source/conv2d.sv
source/cnn_stream.sv
tests/cnn_stream_properties.sv
tests/tb_cnn_stream.sv

// File: run_sim.sh
#!/bin/sh
# Build the cnn_stream testbench with Verilator, run it, and check the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
	--top-module tb_cnn_stream \
	-f cnn_stream.f \
	-o sim_cnn_stream

# The simulator exit status is hidden by tee, the log decides
./obj_dir/sim_cnn_stream | tee sim.log

if grep -qx "Simulation finished: PASS" sim.log; then
	echo "run_sim: cnn_stream test run passed"
	exit 0
else
	echo "run_sim: cnn_stream test run failed, see sim.log"
	exit 1
fi

// File: source/cnn_stream.sv
//--------------------------------------------------
// Early tlast is not forwarded between layers
// Layer 1 realigns only if layer 0 gave no window
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cnn_stream #(
	parameter int IMG_SIDE = 8
) (
	input  wire                     clk,
	input  wire                     reset_i,
	input  wire cnn_types_pkg::sample_t tdata_i,
	input  wire                     tvalid_i,
	input  wire                     tlast_i,
	output wire cnn_types_pkg::sample_t tdata_o,
	output wire                     tvalid_o,
	output wire                     tlast_o
);

	import cnn_types_pkg::*;

	// Stream between the two layers
	sample_t l0_tdata;
	logic    l0_tvalid;
	logic    l0_tlast;

	// IMG_SIDE in, IMG_SIDE-2 out, with ReLU
	conv2d #(.IWIDTH(IMG_SIDE), .ODECIMAL(4), .LAYER(0), .RELU(1'b1)) conv_00 (
		.clk(clk),
		.reset_i(reset_i),
		.tdata_i(tdata_i),
		.tvalid_i(tvalid_i),
		.tlast_i(tlast_i),
		.tdata_o(l0_tdata),
		.tvalid_o(l0_tvalid),
		.tlast_o(l0_tlast)
	);

	// Linear output layer
	conv2d #(.IWIDTH(IMG_SIDE - 2), .ODECIMAL(5), .LAYER(1), .RELU(1'b0)) conv_01 (
		.clk(clk),
		.reset_i(reset_i),
		.tdata_i(l0_tdata),
		.tvalid_i(l0_tvalid),
		.tlast_i(l0_tlast),
		.tdata_o(tdata_o),
		.tvalid_o(tvalid_o),
		.tlast_o(tlast_o)
	);

endmodule

`default_nettype wire

// File: source/cnn_types_pkg.sv
//--------------------------------------------------
// Signed fixed-point samples, 18 bits wide
// Coordinates are 8 bits, so image sides up to 256
//--------------------------------------------------
`default_nettype none

package cnn_types_pkg;

	// Stream sample or activation
	localparam int DATA_W = 18;
	typedef logic signed [DATA_W-1:0] sample_t;

	// Square kernel, taps per window
	localparam int KSIZE = 3;
	localparam int NTAPS = KSIZE * KSIZE;

	// Full sample times weight product
	localparam int PROD_W = 2 * DATA_W;
	typedef logic signed [PROD_W-1:0] prod_t;

	// Nine products need 4 guard bits
	localparam int ACC_W = 40;
	typedef logic signed [ACC_W-1:0] acc_t;

	// Pixel position inside a frame
	typedef logic [7:0] col_t;
	typedef logic [7:0] row_t;

	// Frame FSM in conv_ctrl
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_FILL,
		ST_RUN
	} conv_state_t;

endpackage

`default_nettype wire

// File: source/cnn_weights_pkg.sv
//--------------------------------------------------
// Fixed kernels, same scale as the layer data
// Row-major taps, top-left weight first
//--------------------------------------------------
`default_nettype none

package cnn_weights_pkg;

	localparam int NUM_LAYERS = 2;

	// One row of nine weights per layer
	localparam cnn_types_pkg::sample_t KERNELS
		[0:NUM_LAYERS-1][0:cnn_types_pkg::NTAPS-1] = '{
		// Layer 0 at 4 fraction bits
		// Smoothing with a negative corner, gain 2.0
		'{
			3, 5, 3,
			5, 12, 5,
			3, 5, -9
		},
		// Layer 1 at 5 fraction bits
		// Sharpening cross, gain 1.75
		'{
			-6, 10, -6,
			10, 40, 10,
			-6, 10, -6
		}
	};

endpackage

`default_nettype wire

// File: source/conv2d.sv
//--------------------------------------------------
// One 3x3 layer, output 3 cycles after the pixel
// No ready, so one pixel per cycle at most
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module conv2d #(
	parameter int IWIDTH   = 8,
	parameter int ODECIMAL = 4,
	parameter int LAYER    = 0,
	parameter bit RELU     = 1'b1
) (
	input  wire                     clk,
	input  wire                     reset_i,
	input  wire cnn_types_pkg::sample_t tdata_i,
	input  wire                     tvalid_i,
	input  wire                     tlast_i,
	output wire cnn_types_pkg::sample_t tdata_o,
	output wire                     tvalid_o,
	output wire                     tlast_o
);

	import cnn_types_pkg::*;

	col_t    col;
	row_t    row;
	logic    frame_end;
	logic    clear;
	logic    win_valid;
	logic    win_last;
	logic    win_valid_q;
	logic    win_last_q;
	sample_t win [0:NTAPS-1];

	// Position of the pixel on the input stream
	pixel_counter #(.IWIDTH(IWIDTH)) u_counter (
		.clk(clk),
		.reset_i(reset_i),
		.step_i(tvalid_i),
		.clear_i(clear),
		.col_o(col),
		.row_o(row),
		.frame_end_o(frame_end)
	);

	conv_ctrl u_ctrl (
		.clk(clk),
		.reset_i(reset_i),
		.tvalid_i(tvalid_i),
		.tlast_i(tlast_i),
		.col_i(col),
		.row_i(row),
		.frame_end_i(frame_end),
		.clear_o(clear),
		.win_valid_o(win_valid),
		.win_last_o(win_last)
	);

	line_buffer #(.IWIDTH(IWIDTH)) u_lines (
		.clk(clk),
		.reset_i(reset_i),
		.shift_i(tvalid_i),
		.pixel_i(tdata_i),
		.win_o(win)
	);

	// Flags line up with the window registers
	always_ff @(posedge clk) begin
		if (reset_i) begin
			win_valid_q <= 1'b0;
			win_last_q  <= 1'b0;
		end else begin
			win_valid_q <= win_valid;
			win_last_q  <= win_last;
		end
	end

	mac_array #(.LAYER(LAYER), .ODECIMAL(ODECIMAL), .RELU(RELU)) u_mac (
		.clk(clk),
		.reset_i(reset_i),
		.win_valid_i(win_valid_q),
		.win_last_i(win_last_q),
		.win_i(win),
		.tdata_o(tdata_o),
		.tvalid_o(tvalid_o),
		.tlast_o(tlast_o)
	);

endmodule

`default_nettype wire

// File: source/conv_ctrl.sv
//--------------------------------------------------
// Kernel fixed at 3x3, stride 1, no padding
// Early tlast aborts the frame without a tlast out
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module conv_ctrl (
	input  wire                  clk,
	input  wire                  reset_i,
	input  wire                  tvalid_i,
	input  wire                  tlast_i,
	input  wire cnn_types_pkg::col_t col_i,
	input  wire cnn_types_pkg::row_t row_i,
	input  wire                  frame_end_i,
	output logic                 clear_o,
	output logic                 win_valid_o,
	output logic                 win_last_o
);

	import cnn_types_pkg::*;

	conv_state_t state_q;
	conv_state_t state_d;
	logic        early_end;

	// tlast anywhere but the bottom-right pixel
	assign early_end = tvalid_i && tlast_i && !frame_end_i;

	// Restart the counter on an aborted frame
	assign clear_o = early_end;

	// Full window once two rows and two columns are in
	assign win_valid_o = tvalid_i && (state_q == ST_RUN) &&
		(col_i >= col_t'(KSIZE - 1));

	// Last window sits at the regular frame end
	assign win_last_o = win_valid_o && frame_end_i;

	always_comb begin
		state_d = state_q;
		if (tvalid_i) begin
			if (early_end || frame_end_i) begin
				// Frame closed, normally or not
				state_d = ST_IDLE;
			end else begin
				case (state_q)
					ST_IDLE: state_d = ST_FILL;
					ST_FILL: begin
						// First pixel of row 2 starts the windows
						if (row_i >= row_t'(KSIZE - 1)) begin
							state_d = ST_RUN;
						end
					end
					default: state_d = state_q;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state_q <= ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

endmodule

`default_nettype wire

// File: source/line_buffer.sv
//--------------------------------------------------
// Shifts on every pixel, window valid is tracked outside
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module line_buffer #(
	parameter int IWIDTH = 8
) (
	input  wire                     clk,
	input  wire                     reset_i,
	input  wire                     shift_i,
	input  wire cnn_types_pkg::sample_t pixel_i,
	output cnn_types_pkg::sample_t  win_o [0:cnn_types_pkg::NTAPS-1]
);

	import cnn_types_pkg::*;

	// Previous row and the row before it
	sample_t line0_q [0:IWIDTH-1];
	sample_t line1_q [0:IWIDTH-1];
	sample_t tap0;
	sample_t tap1;

	// Same column one and two rows up
	assign tap0 = line0_q[IWIDTH-1];
	assign tap1 = line1_q[IWIDTH-1];

	// Second line is fed from the first
	always_ff @(posedge clk) begin
		if (shift_i) begin
			line0_q[0] <= pixel_i;
			line1_q[0] <= tap0;
			for (int i = 1; i < IWIDTH; i++) begin
				line0_q[i] <= line0_q[i-1];
				line1_q[i] <= line1_q[i-1];
			end
		end
	end

	// Window moves one column left per pixel
	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < NTAPS; i++) begin
				win_o[i] <= '0;
			end
		end else if (shift_i) begin
			for (int r = 0; r < KSIZE; r++) begin
				for (int c = 0; c < KSIZE - 1; c++) begin
					win_o[r*KSIZE + c] <= win_o[r*KSIZE + c + 1];
				end
			end
			// New right column, oldest row on top
			win_o[KSIZE-1]   <= tap1;
			win_o[2*KSIZE-1] <= tap0;
			win_o[NTAPS-1]   <= pixel_i;
		end
	end

endmodule

`default_nettype wire

// File: source/mac_array.sv
//--------------------------------------------------
// Two cycles from window to result
// Shift rounds toward minus infinity
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mac_array #(
	parameter int LAYER    = 0,
	parameter int ODECIMAL = 4,
	parameter bit RELU     = 1'b1
) (
	input  wire                     clk,
	input  wire                     reset_i,
	input  wire                     win_valid_i,
	input  wire                     win_last_i,
	input  wire cnn_types_pkg::sample_t win_i [0:cnn_types_pkg::NTAPS-1],
	output cnn_types_pkg::sample_t  tdata_o,
	output logic                    tvalid_o,
	output logic                    tlast_o
);

	import cnn_types_pkg::*;
	import cnn_weights_pkg::*;

	// Sample range in accumulator terms
	localparam acc_t SAT_HI = (acc_t'(1) <<< (DATA_W - 1)) - acc_t'(1);
	localparam acc_t SAT_LO = -(acc_t'(1) <<< (DATA_W - 1));

	prod_t   prod_q [0:NTAPS-1];
	logic    valid_q;
	logic    last_q;
	acc_t    sum;
	acc_t    scaled;
	sample_t result;

	// Stage 1 multiplies each tap by its weight
	always_ff @(posedge clk) begin
		for (int i = 0; i < NTAPS; i++) begin
			prod_q[i] <= prod_t'(win_i[i]) * prod_t'(KERNELS[LAYER][i]);
		end
	end

	// Stage 2 adder tree, rescale and clamp
	always_comb begin
		sum = '0;
		for (int i = 0; i < NTAPS; i++) begin
			sum = sum + acc_t'(prod_q[i]);
		end
		// Drop the weight fraction bits
		scaled = sum >>> ODECIMAL;
		if (scaled > SAT_HI) begin
			result = sample_t'(SAT_HI);
		end else if (scaled < SAT_LO) begin
			result = sample_t'(SAT_LO);
		end else begin
			result = sample_t'(scaled);
		end
		// ReLU
		if (RELU && (result < 0)) begin
			result = '0;
		end
	end

	always_ff @(posedge clk) begin
		tdata_o <= result;
	end

	// Flags ride alongside the two data stages
	always_ff @(posedge clk) begin
		if (reset_i) begin
			valid_q  <= 1'b0;
			last_q   <= 1'b0;
			tvalid_o <= 1'b0;
			tlast_o  <= 1'b0;
		end else begin
			valid_q  <= win_valid_i;
			last_q   <= win_last_i;
			tvalid_o <= valid_q;
			tlast_o  <= last_q;
		end
	end

endmodule

`default_nettype wire

// File: source/pixel_counter.sv
//--------------------------------------------------
// Counts only strobed pixels, IWIDTH at most 256
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pixel_counter #(
	parameter int IWIDTH = 8
) (
	input  wire                  clk,
	input  wire                  reset_i,
	input  wire                  step_i,
	input  wire                  clear_i,
	output cnn_types_pkg::col_t  col_o,
	output cnn_types_pkg::row_t  row_o,
	output logic                 frame_end_o
);

	import cnn_types_pkg::*;

	// Last position of a row and of a frame
	localparam col_t LAST_COL = col_t'(IWIDTH - 1);
	localparam row_t LAST_ROW = row_t'(IWIDTH - 1);

	logic row_end;

	// Current pixel is the last of its row
	assign row_end = (col_o == LAST_COL);

	// Bottom-right pixel of the frame
	assign frame_end_o = row_end && (row_o == LAST_ROW);

	always_ff @(posedge clk) begin
		if (reset_i || clear_i) begin
			col_o <= '0;
			row_o <= '0;
		end else if (step_i) begin
			if (frame_end_o) begin
				// Wrap for the next frame
				col_o <= '0;
				row_o <= '0;
			end else if (row_end) begin
				col_o <= '0;
				row_o <= row_o + row_t'(1);
			end else begin
				col_o <= col_o + col_t'(1);
			end
		end
	end

endmodule

`default_nettype wire

// File: tests/cnn_stream_properties.sv
//--------------------------------------------------
// Bound to cnn_stream, also watches the layer-0 stream
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cnn_stream_properties (
	input wire                          clk,
	input wire                          reset_i,
	input wire                          tvalid_i,
	input wire                          tlast_i,
	input wire cnn_types_pkg::sample_t  l0_tdata_i,
	input wire                          l0_tvalid_i
);

	import cnn_types_pkg::*;

	// Pipeline flags are cleared by reset
	a_idle_after_reset: assert property (@(posedge clk) reset_i |=> !tvalid_i)
		else $error("tvalid_o high in the cycle after reset");

	// Frame end marker only on a real output
	a_last_with_valid: assert property (@(posedge clk) disable iff (reset_i)
		tlast_i |-> tvalid_i)
		else $error("tlast_o high without tvalid_o");

	// ReLU in layer 0 keeps the sign bit clear
	a_l0_not_negative: assert property (@(posedge clk) disable iff (reset_i)
		l0_tvalid_i |-> !l0_tdata_i[DATA_W-1])
		else $error("negative layer-0 output while valid");

endmodule

bind cnn_stream cnn_stream_properties u_props (
	.clk(clk),
	.reset_i(reset_i),
	.tvalid_i(tvalid_o),
	.tlast_i(tlast_o),
	.l0_tdata_i(l0_tdata),
	.l0_tvalid_i(l0_tvalid)
);

`default_nettype wire

// File: tests/tb_cnn_stream.sv
//--------------------------------------------------
// Expected data from a model of both layers
// Early tlast only before the first layer-0 window
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_cnn_stream;

	import cnn_types_pkg::*;
	import cnn_weights_pkg::*;

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 8;
	localparam int IMG_SIDE     = 8;
	localparam int L0_SIDE      = IMG_SIDE - 2;
	localparam int OUT_SIDE     = IMG_SIDE - 4;
	localparam int IMG_PIXELS   = IMG_SIDE * IMG_SIDE;
	localparam int OUT_PIXELS   = OUT_SIDE * OUT_SIDE;
	localparam int PIPE_LATENCY = 6;
	localparam int MAX_TESTS    = 16;
	localparam int SAMPLE_MAX   = (1 << (DATA_W - 1)) - 1;
	localparam int SAMPLE_MIN   = -(1 << (DATA_W - 1));
	// Pattern kinds
	localparam int PAT_RAMP     = 0;
	localparam int PAT_RANDOM   = 1;
	localparam int PAT_POS      = 2;
	localparam int PAT_NEG      = 3;

	logic    clk = 1'b0;
	logic    reset_i;
	sample_t tdata_i;
	logic    tvalid_i;
	logic    tlast_i;
	sample_t tdata_o;
	wire     tvalid_o;
	wire     tlast_o;

	int    seed = 32'h3848_66dd;
	int    cycle = 0;
	int    error_count = 0;
	int    num_tests = 0;
	logic  table_ready = 1'b0;
	// Test table
	string test_name  [0:MAX_TESTS-1];
	int    test_pat   [0:MAX_TESTS-1];
	int    test_gap   [0:MAX_TESTS-1];
	int    test_early [0:MAX_TESTS-1];
	// Current frame and its model results
	int    frame_pix [0:IMG_PIXELS-1];
	int    l0_map    [0:L0_SIDE*L0_SIDE-1];
	int    exp_out   [0:OUT_PIXELS-1];
	// Outputs still to come, in stream order
	int    exp_data_q[$];
	int    exp_cycle_q[$];
	int    exp_last_q[$];
	int    exp_test_q[$];

	cnn_stream #(.IMG_SIDE(IMG_SIDE)) UUT (
		.clk(clk),
		.reset_i(reset_i),
		.tdata_i(tdata_i),
		.tvalid_i(tvalid_i),
		.tlast_i(tlast_i),
		.tdata_o(tdata_o),
		.tvalid_o(tvalid_o),
		.tlast_o(tlast_o)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	task automatic end_with_failure();
		error_count++;
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check(input string what, input int expected, input int actual);
		if (expected != actual) begin
			$display("mismatch %s: expected %0d, actual %0d", what, expected, actual);
			end_with_failure();
		end
	endtask

	task automatic add_test(input string name, input int pat, input int gap, input int early);
		test_name[num_tests]  = name;
		test_pat[num_tests]   = pat;
		test_gap[num_tests]   = gap;
		test_early[num_tests] = early;
		num_tests++;
	endtask

	// Rescale, saturate to the sample range, optional ReLU
	function automatic int shift_saturate(input longint sum, input int shift, input bit relu);
		longint scaled;
		scaled = sum >>> shift;
		if (scaled > SAMPLE_MAX) begin
			scaled = SAMPLE_MAX;
		end else if (scaled < SAMPLE_MIN) begin
			scaled = SAMPLE_MIN;
		end
		if (relu && (scaled < 0)) begin
			scaled = 0;
		end
		return int'(scaled);
	endfunction

	task automatic build_frame(input int t);
		for (int p = 0; p < IMG_PIXELS; p++) begin
			case (test_pat[t])
				PAT_RAMP:   frame_pix[p] = p * 53 - 1500 + t * 11;
				PAT_RANDOM: frame_pix[p] = $random(seed) % 4096;
				PAT_POS:    frame_pix[p] = SAMPLE_MAX - (p % 7);
				default:    frame_pix[p] = SAMPLE_MIN + (p % 5);
			endcase
		end
	endtask

	// Layer 0 with shift 4 and ReLU, layer 1 with shift 5 and no ReLU
	task automatic model_frame();
		longint sum;
		for (int r = 0; r < L0_SIDE; r++) begin
			for (int c = 0; c < L0_SIDE; c++) begin
				sum = 0;
				for (int k = 0; k < NTAPS; k++) begin
					sum += longint'(frame_pix[(r + k / KSIZE) * IMG_SIDE + c + k % KSIZE]) *
						longint'(KERNELS[0][k]);
				end
				l0_map[r * L0_SIDE + c] = shift_saturate(sum, 4, 1'b1);
			end
		end
		for (int r = 0; r < OUT_SIDE; r++) begin
			for (int c = 0; c < OUT_SIDE; c++) begin
				sum = 0;
				for (int k = 0; k < NTAPS; k++) begin
					sum += longint'(l0_map[(r + k / KSIZE) * L0_SIDE + c + k % KSIZE]) *
						longint'(KERNELS[1][k]);
				end
				exp_out[r * OUT_SIDE + c] = shift_saturate(sum, 5, 1'b0);
			end
		end
	endtask

	task automatic send_frame(input int t);
		int len;
		int gap;
		int r;
		int c;
		int o;
		len = (test_early[t] >= 0) ? test_early[t] + 1 : IMG_PIXELS;
		for (int p = 0; p < len; p++) begin
			gap = 0;
			if (test_gap[t] > 0) begin
				gap = $random(seed) % (test_gap[t] + 1);
				if (gap < 0) begin
					gap = -gap;
				end
			end
			repeat (gap) begin
				@(posedge clk);
				#1;
				tvalid_i = 1'b0;
				tlast_i  = 1'b0;
			end
			@(posedge clk);
			#1;
			tdata_i  = sample_t'(frame_pix[p]);
			tvalid_i = 1'b1;
			tlast_i  = (p == len - 1);
			r = p / IMG_SIDE;
			c = p % IMG_SIDE;
			// This pixel closes final window (r-4, c-4)
			if ((test_early[t] < 0) && (r >= IMG_SIDE - OUT_SIDE) &&
				(c >= IMG_SIDE - OUT_SIDE)) begin
				o = (r - (IMG_SIDE - OUT_SIDE)) * OUT_SIDE + c - (IMG_SIDE - OUT_SIDE);
				exp_data_q.push_back(exp_out[o]);
				exp_cycle_q.push_back(cycle);
				exp_last_q.push_back((o == OUT_PIXELS - 1) ? 1 : 0);
				exp_test_q.push_back(t);
			end
		end
	endtask

	// Sampled mid-cycle, away from the driving edge
	always @(negedge clk) begin : monitor
		int test_idx;
		int pix_cycle;
		if (!reset_i && tvalid_o) begin
			if (exp_data_q.size() == 0) begin
				$display("unexpected output: tvalid_o high with no window pending, data %0d",
					int'(tdata_o));
				end_with_failure();
			end else begin
				test_idx  = exp_test_q.pop_front();
				pix_cycle = exp_cycle_q.pop_front();
				check({test_name[test_idx], " data"}, exp_data_q.pop_front(), int'(tdata_o));
				check({test_name[test_idx], " latency"}, PIPE_LATENCY, cycle - pix_cycle);
				check({test_name[test_idx], " tlast"}, exp_last_q.pop_front(), int'(tlast_o));
			end
		end
	end

	// Limit scales with pixels and the longest idle gap
	initial begin : watchdog
		int limit;
		int max_gap;
		int pixels;
		wait (table_ready);
		max_gap = 0;
		pixels  = 0;
		for (int t = 0; t < num_tests; t++) begin
			pixels += (test_early[t] >= 0) ? test_early[t] + 1 : IMG_PIXELS;
			if (test_gap[t] > max_gap) begin
				max_gap = test_gap[t];
			end
		end
		limit = RESET_CYCLES + pixels * (max_gap + 1) + 100;
		repeat (limit) @(posedge clk);
		$display("timeout: outputs still missing after %0d cycles", limit);
		end_with_failure();
	end

	initial begin
		reset_i  = 1'b1;
		tdata_i  = '0;
		tvalid_i = 1'b0;
		tlast_i  = 1'b0;
		// name, pattern, max idle cycles per pixel, early tlast position or -1
		add_test("ramp_b2b",    PAT_RAMP,   0, -1);
		add_test("random_gaps", PAT_RANDOM, 3, -1);
		add_test("pos_sat",     PAT_POS,    0, -1);
		add_test("neg_relu",    PAT_NEG,    0, -1);
		add_test("random_b2b",  PAT_RANDOM, 0, -1);
		add_test("ramp_b2b_2",  PAT_RAMP,   0, -1);
		add_test("early_row1",  PAT_RAMP,   0, 13);
		add_test("after_early", PAT_RANDOM, 0, -1);
		add_test("early_row2",  PAT_RANDOM, 1, 17);
		add_test("after_gaps",  PAT_RAMP,   2, -1);
		table_ready = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset_i = 1'b0;
		// Frames follow each other with no idle cycle
		for (int t = 0; t < num_tests; t++) begin
			build_frame(t);
			model_frame();
			send_frame(t);
		end
		@(posedge clk);
		#1;
		tvalid_i = 1'b0;
		tlast_i  = 1'b0;
		while (exp_data_q.size() != 0) begin
			@(posedge clk);
		end
		// Catch stray outputs after the last frame
		repeat (20) @(posedge clk);
		if (error_count == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			end_with_failure();
		end
	end

endmodule

`default_nettype wire
